// File: include/tiny_pipe_consts.svh
`ifndef TINY_PIPE_CONSTS_SVH
`define TINY_PIPE_CONSTS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

// data path and address width
`define XLEN 32

// architectural register count, r0 reads zero
`define REG_COUNT 16
`define REG_IDX_W 4

////////////////////////////////////////
// fetch constants
////////////////////////////////////////

// first fetch address after reset
`define RESET_PC {`XLEN{1'b0}}
// byte distance between two instructions
`define PC_STEP 4
// all-zero word, decodes as nop
`define NOP_INST {`XLEN{1'b0}}

`endif

// File: source/decode_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "tiny_pipe_consts.svh"

module decode_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    dispatch_en,
    input  logic                    rollback,
    input  tiny_pipe_pkg::if_id_t   if_id,
    input  logic [`XLEN-1:0]        rs1_value,
    input  logic [`XLEN-1:0]        rs2_value,
    output logic [`REG_IDX_W-1:0]   rs1_idx,
    output logic [`REG_IDX_W-1:0]   rs2_idx,
    output tiny_pipe_pkg::reg_req_t reg_req,
    output tiny_pipe_pkg::id_ex_t   id_ex
);
    import tiny_pipe_pkg::*;

    // raw fields, one format for every opcode
    logic [3:0]            opcode;
    logic [`REG_IDX_W-1:0] rd;
    logic [15:0]           imm16;
    // opcode class
    logic                  writer;
    logic                  uses_rs1;
    logic                  uses_rs2;
    logic                  is_branch;
    logic                  is_halt;
    logic                  is_illegal;
    id_ex_t                dec_pkt;

    assign opcode = if_id.inst[31:28];
    assign rd     = if_id.inst[27:24];
    assign imm16  = if_id.inst[15:0];

    always_comb begin
        writer     = 1'b0;
        uses_rs1   = 1'b0;
        uses_rs2   = 1'b0;
        is_branch  = 1'b0;
        is_halt    = 1'b0;
        is_illegal = 1'b0;
        case (opcode_e'(opcode))
            op_nop: begin
            end
            op_add, op_sub, op_and, op_xor: begin
                writer   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            op_addi: begin
                writer   = 1'b1;
                uses_rs1 = 1'b1;
            end
            op_beq, op_bne: begin
                is_branch = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            op_halt: is_halt = 1'b1;
            default: is_illegal = 1'b1;
        endcase
    end

    // unused sources read r0 so they never stall
    assign rs1_idx = uses_rs1 ? if_id.inst[23:20] : '0;
    assign rs2_idx = uses_rs2 ? if_id.inst[19:16] : '0;

    assign reg_req = '{valid: if_id.valid, rs1: rs1_idx, rs2: rs2_idx, rd: rd,
                       write_en: writer, freeze: is_halt || is_illegal};

    always_comb begin
        dec_pkt            = '0;
        dec_pkt.valid      = if_id.valid;
        dec_pkt.pc         = if_id.pc;
        dec_pkt.op         = opcode_e'(opcode);
        dec_pkt.rd         = rd;
        dec_pkt.write_en   = writer;
        dec_pkt.rs1_value  = rs1_value;
        dec_pkt.rs2_value  = rs2_value;
        // sign extension
        dec_pkt.imm        = {{(`XLEN-16){imm16[15]}}, imm16};
        dec_pkt.is_branch  = is_branch;
        dec_pkt.is_halt    = is_halt;
        dec_pkt.is_illegal = is_illegal;
    end

    // id/ex register, bubble unless dispatched
    always_ff @(posedge clock) begin
        if (dispatch_en) begin
            id_ex <= dec_pkt;
        end
        if (reset) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= dispatch_en && !rollback;
        end
    end

endmodule

`default_nettype wire

// File: source/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "tiny_pipe_consts.svh"

module exec_unit (
    input  logic                     clock,
    input  logic                     reset,
    input  tiny_pipe_pkg::id_ex_t    id_ex,
    output tiny_pipe_pkg::redirect_t redirect,
    output tiny_pipe_pkg::commit_t   commit
);
    import tiny_pipe_pkg::*;

    logic [`XLEN-1:0] result;
    // branch condition holds
    logic             cond;
    logic [`XLEN-1:0] target;

    ////////////////////////////////////////
    // alu and branch compare
    ////////////////////////////////////////

    always_comb begin
        result = '0;
        cond   = 1'b0;
        case (id_ex.op)
            op_add:  result = id_ex.rs1_value + id_ex.rs2_value;
            op_sub:  result = id_ex.rs1_value - id_ex.rs2_value;
            op_and:  result = id_ex.rs1_value & id_ex.rs2_value;
            op_xor:  result = id_ex.rs1_value ^ id_ex.rs2_value;
            op_addi: result = id_ex.rs1_value + id_ex.imm;
            op_beq:  cond = (id_ex.rs1_value == id_ex.rs2_value);
            op_bne:  cond = (id_ex.rs1_value != id_ex.rs2_value);
            // nop, halt and illegal produce nothing
            default: begin
            end
        endcase
    end

    // immediate counts instructions, not bytes
    assign target = id_ex.pc + id_ex.imm * `PC_STEP;

    // redirect straight from the current id/ex packet
    assign redirect.take   = id_ex.valid && id_ex.is_branch && cond;
    assign redirect.target = target;

    ////////////////////////////////////////
    // ex/co register
    ////////////////////////////////////////

    // every valid instruction commits, only writers with wr_en
    always_ff @(posedge clock) begin
        commit.pc         <= id_ex.pc;
        commit.wr_en      <= id_ex.write_en;
        commit.wr_idx     <= id_ex.rd;
        commit.wr_data    <= result;
        commit.is_halt    <= id_ex.is_halt;
        commit.is_illegal <= id_ex.is_illegal;
        if (reset) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= id_ex.valid;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "tiny_pipe_consts.svh"

module fetch_unit (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     stall,
    input  logic                     fetch_en,
    input  tiny_pipe_pkg::redirect_t redirect,
    input  logic [`XLEN-1:0]         fetch_inst,
    output logic [`XLEN-1:0]         fetch_addr,
    output tiny_pipe_pkg::if_id_t    if_id
);

    logic [`XLEN-1:0] pc;
    // a real instruction enters if/id this cycle
    logic             advance;
    // if/id takes a new value, real or bubble
    logic             load;

    assign advance    = fetch_en && !stall && !redirect.take;
    assign load       = redirect.take || !stall;
    // instruction memory is combinational on the current pc
    assign fetch_addr = pc;

    // redirect wins over stall
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (redirect.take) begin
            pc <= redirect.target;
        end else if (advance) begin
            pc <= pc + `PC_STEP;
        end
    end

    // if/id register, held on stall, bubble on redirect or freeze
    always_ff @(posedge clock) begin
        if (load) begin
            if_id.pc   <= pc;
            if_id.inst <= advance ? fetch_inst : `NOP_INST;
        end
        if (reset) begin
            if_id.valid <= 1'b0;
        end else if (load) begin
            if_id.valid <= advance;
        end
    end

endmodule

`default_nettype wire

// File: source/pipe_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "tiny_pipe_consts.svh"

module pipe_control (
    input  logic                    clock,
    input  logic                    reset,
    input  tiny_pipe_pkg::reg_req_t  reg_req,
    input  tiny_pipe_pkg::redirect_t redirect,
    input  tiny_pipe_pkg::commit_t   commit,
    output logic                    stall,
    output logic                    rollback,
    output logic                    dispatch_en,
    output logic                    fetch_en,
    output tiny_pipe_pkg::status_e   status
);
    import tiny_pipe_pkg::*;

    // one pending-write bit per register
    logic [`REG_COUNT-1:0] busy;
    logic [`REG_COUNT-1:0] busy_next;
    // set once a halt or illegal instruction dispatches
    logic                  frozen;
    logic                  src_busy;
    logic                  dst_busy;

    ////////////////////////////////////////
    // stall and dispatch
    ////////////////////////////////////////

    // r0 never waits
    assign src_busy = (reg_req.rs1 != '0 && busy[reg_req.rs1])
                   || (reg_req.rs2 != '0 && busy[reg_req.rs2]);
    // a second writer to the same register waits for the first
    assign dst_busy = reg_req.write_en && reg_req.rd != '0 && busy[reg_req.rd];

    assign stall       = reg_req.valid && (src_busy || dst_busy);
    assign rollback    = redirect.take;
    assign dispatch_en = reg_req.valid && !stall && !rollback && !frozen;
    assign fetch_en    = !frozen;

    ////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////

    always_comb begin
        busy_next = busy;
        // retiring write frees its register
        if (commit.valid && commit.wr_en && commit.wr_idx != '0) begin
            busy_next[commit.wr_idx] = 1'b0;
        end
        // dispatched writer claims its register
        if (dispatch_en && reg_req.write_en && reg_req.rd != '0) begin
            busy_next[reg_req.rd] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy   <= '0;
            frozen <= 1'b0;
            status <= status_ok;
        end else begin
            busy <= busy_next;
            if (dispatch_en && reg_req.freeze) begin
                frozen <= 1'b1;
            end
            // first halt or illegal commit sticks until reset
            if (status == status_ok && commit.valid) begin
                if (commit.is_illegal) begin
                    status <= status_illegal;
                end else if (commit.is_halt) begin
                    status <= status_halted;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "tiny_pipe_consts.svh"

module reg_file (
    input  logic                  clock,
    input  logic [`REG_IDX_W-1:0] rs1_idx,
    input  logic [`REG_IDX_W-1:0] rs2_idx,
    input  tiny_pipe_pkg::commit_t commit,
    output logic [`XLEN-1:0]      rs1_value,
    output logic [`XLEN-1:0]      rs2_value
);

    // contents start cleared
    logic [`XLEN-1:0] regs [`REG_COUNT] = '{default: '0};

    // combinational reads, r0 hardwired to zero
    assign rs1_value = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_value = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    // write port fed by the commit bus
    always_ff @(posedge clock) begin
        if (commit.valid && commit.wr_en && commit.wr_idx != '0) begin
            regs[commit.wr_idx] <= commit.wr_data;
        end
    end

endmodule

`default_nettype wire

// File: source/tiny_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "tiny_pipe_consts.svh"

module tiny_pipe (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       fetch_inst,
    output logic [`XLEN-1:0]       fetch_addr,
    output tiny_pipe_pkg::commit_t commit,
    output tiny_pipe_pkg::status_e status
);
    import tiny_pipe_pkg::*;

    ////////////////////////////////////////
    // pipeline wires
    ////////////////////////////////////////

    // control levels
    logic                  stall;
    logic                  rollback;
    logic                  dispatch_en;
    logic                  fetch_en;
    // stage packets
    if_id_t                if_id;
    id_ex_t                id_ex;
    redirect_t             redirect;
    reg_req_t              reg_req;
    // register file read ports
    logic [`REG_IDX_W-1:0] rs1_idx;
    logic [`REG_IDX_W-1:0] rs2_idx;
    logic [`XLEN-1:0]      rs1_value;
    logic [`XLEN-1:0]      rs2_value;

    pipe_control pipe_control_0 (
        .clock(clock), .reset(reset), .reg_req(reg_req), .redirect(redirect),
        .commit(commit), .stall(stall), .rollback(rollback),
        .dispatch_en(dispatch_en), .fetch_en(fetch_en), .status(status)
    );

    fetch_unit fetch_unit_0 (
        .clock(clock), .reset(reset), .stall(stall), .fetch_en(fetch_en),
        .redirect(redirect), .fetch_inst(fetch_inst), .fetch_addr(fetch_addr),
        .if_id(if_id)
    );

    decode_unit decode_unit_0 (
        .clock(clock), .reset(reset), .dispatch_en(dispatch_en), .rollback(rollback),
        .if_id(if_id), .rs1_value(rs1_value), .rs2_value(rs2_value),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .reg_req(reg_req), .id_ex(id_ex)
    );

    // written by the commit bus
    reg_file reg_file_0 (
        .clock(clock), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .commit(commit),
        .rs1_value(rs1_value), .rs2_value(rs2_value)
    );

    exec_unit exec_unit_0 (
        .clock(clock), .reset(reset), .id_ex(id_ex), .redirect(redirect),
        .commit(commit)
    );

endmodule

`default_nettype wire

// File: source/tiny_pipe_pkg.sv
`default_nettype none

`include "tiny_pipe_consts.svh"

package tiny_pipe_pkg;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // top nibble of the instruction word
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_xor  = 4'd4,
        op_addi = 4'd5,
        op_beq  = 4'd6,
        op_bne  = 4'd7,
        op_halt = 4'd15
    } opcode_e;

    // sticky status, only leaves ok once
    typedef enum logic [1:0] {
        status_ok      = 2'd0,
        status_halted  = 2'd1,
        status_illegal = 2'd2
    } status_e;

    ////////////////////////////////////////
    // packets
    ////////////////////////////////////////

    // fetch to decode
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } if_id_t;

    // decode to execute, sources already read
    typedef struct packed {
        logic                  valid;
        logic [`XLEN-1:0]      pc;
        opcode_e               op;
        logic [`REG_IDX_W-1:0] rd;
        logic                  write_en;
        logic [`XLEN-1:0]      rs1_value;
        logic [`XLEN-1:0]      rs2_value;
        logic [`XLEN-1:0]      imm;
        logic                  is_branch;
        logic                  is_halt;
        logic                  is_illegal;
    } id_ex_t;

    // taken branch from execute
    typedef struct packed {
        logic             take;
        logic [`XLEN-1:0] target;
    } redirect_t;

    // retired instruction, also the register write port
    typedef struct packed {
        logic                  valid;
        logic [`XLEN-1:0]      pc;
        logic                  wr_en;
        logic [`REG_IDX_W-1:0] wr_idx;
        logic [`XLEN-1:0]      wr_data;
        logic                  is_halt;
        logic                  is_illegal;
    } commit_t;

    // decode request to the scoreboard
    // freeze marks a halt or illegal instruction
    typedef struct packed {
        logic                  valid;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rd;
        logic                  write_en;
        logic                  freeze;
    } reg_req_t;

endpackage

`default_nettype wire

// File: test/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 4
) (
    input  logic restart,
    output logic clock,
    output logic reset
);

    // falling edges seen under the current reset
    int count;

    // free-running clock
    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // reset at time zero, again on each restart request
    // only moves on the falling edge
    initial begin
        reset = 1'b1;
        count = 0;
        forever begin
            @(negedge clock);
            if (restart) begin
                reset <= 1'b1;
                count = 0;
            end else if (reset) begin
                count = count + 1;
                // drop after reset_cycles rising edges
                if (count >= reset_cycles) begin
                    reset <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tiny_pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "tiny_pipe_consts.svh"

module tiny_pipe_tb;
    import tiny_pipe_pkg::*;

    // one expected retirement
    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic                  wr_en;
        logic [`REG_IDX_W-1:0] wr_idx;
        logic [`XLEN-1:0]      wr_data;
        // stop kind of the closing instruction
        logic                  is_halt;
        logic                  is_illegal;
    } retire_t;

    ////////////////////////////////////////
    // run length and stimulus constants
    ////////////////////////////////////////

    localparam int prog_words      = 24;
    localparam int cycles_per_inst = 8;
    localparam int test_margin     = 20;
    localparam int test_count      = 7;
    localparam int tail_cycles     = 4;
    localparam int test_limit      = prog_words * cycles_per_inst;
    localparam int watchdog_cycles = test_count * (test_limit + test_margin) + 50;
    // program shapes
    localparam int kind_indep      = 0;
    localparam int kind_dense      = 1;
    localparam int kind_branch     = 2;
    localparam int kind_halt       = 3;
    localparam int kind_illegal    = 4;
    localparam logic [31:0] lfsr_seed = 32'd40;
    // x^32 + x^22 + x^2 + x + 1, right-shifting form
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;
    localparam logic [`XLEN-1:0] halt_word = {op_halt, 28'h0};

    logic             clock;
    logic             reset;
    logic             restart = 1'b0;
    logic [`XLEN-1:0] fetch_inst = `NOP_INST;
    logic [`XLEN-1:0] fetch_addr;
    commit_t          commit;
    status_e          status;

    // program image, anything past prog_len reads as halt
    logic [`XLEN-1:0] program_mem [prog_words];
    int               prog_len = 0;
    // architectural state, carried over resets like the DUT file
    logic [`XLEN-1:0] model_regs [`REG_COUNT] = '{default: '0};
    retire_t          expected [$];
    status_e          exp_status;
    logic [31:0]      lfsr_state = lfsr_seed;
    int               error_count = 0;
    int               tests_passed = 0;
    int               tests_failed = 0;

    clock_gen clock_source (.restart(restart), .clock(clock), .reset(reset));

    tiny_pipe UUT (
        .clock(clock), .reset(reset), .fetch_inst(fetch_inst),
        .fetch_addr(fetch_addr), .commit(commit), .status(status)
    );

    ////////////////////////////////////////
    // random bits
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic [`XLEN-1:0] encode(logic [3:0] op, logic [3:0] rd,
                                               logic [3:0] rs1, logic [3:0] rs2,
                                               logic [15:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    function automatic logic [`XLEN-1:0] image_word(logic [`XLEN-1:0] addr);
        if ((addr / `PC_STEP) < prog_len) begin
            return program_mem[addr / `PC_STEP];
        end
        return halt_word;
    endfunction

    // instruction memory answers on the falling edge
    always @(negedge clock) begin
        fetch_inst <= image_word(fetch_addr);
    end

    ////////////////////////////////////////
    // program generator and isa model
    ////////////////////////////////////////

    task automatic build_program(input int kind);
        int          i;
        int          stop;
        logic [3:0]  op;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [15:0] imm;
        prog_len = prog_words;
        // where halt or the illegal word lands
        stop = 8 + take_bits(3);
        for (i = 0; i < prog_words - 1; i++) begin
            op = 4'(1 + take_bits(3) % 5);
            imm = (op == op_addi) ? 16'(take_bits(16)) : 16'h0;
            case (kind)
                kind_indep: begin
                    // seed r1..r7, then write r8..r15 round robin
                    if (i < 7) begin
                        op = op_addi;
                        rd = 4'(i + 1);
                        rs1 = 4'h0;
                        rs2 = 4'h0;
                        imm = 16'(take_bits(16));
                    end else begin
                        rd = 4'(8 + i % 8);
                        // r1..r5 retire before any reader decodes
                        rs1 = 4'(1 + take_bits(3) % 5);
                        rs2 = 4'(1 + take_bits(3) % 5);
                    end
                end
                kind_dense: begin
                    // three registers only, nearly every pair depends
                    rd = 4'(1 + take_bits(2) % 3);
                    rs1 = 4'(take_bits(2));
                    rs2 = 4'(take_bits(2));
                end
                kind_branch: begin
                    rd = 4'(1 + take_bits(2));
                    rs1 = 4'(take_bits(3) % 6);
                    rs2 = take_bits(1) ? rs1 : 4'(take_bits(3) % 6);
                    // forward only, one to four instructions
                    if (take_bits(2) == 0) begin
                        op = take_bits(1) ? op_beq : op_bne;
                        imm = 16'(1 + take_bits(2));
                    end
                end
                default: begin
                    rd = 4'(take_bits(4));
                    rs1 = 4'(take_bits(4));
                    rs2 = 4'(take_bits(4));
                end
            endcase
            program_mem[i] = encode(op, rd, rs1, rs2, imm);
        end
        if (kind == kind_halt) begin
            program_mem[stop] = halt_word;
        end
        if (kind == kind_illegal) begin
            program_mem[stop] = encode(4'(8 + take_bits(3) % 7), 4'(take_bits(4)),
                                       4'h0, 4'h0, 16'h0);
        end
        program_mem[prog_words - 1] = halt_word;
    endtask

    // walks the image in order, queues every retirement
    task automatic run_model();
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      next_pc;
        logic [`XLEN-1:0]      inst;
        logic [`XLEN-1:0]      a;
        logic [`XLEN-1:0]      b;
        logic [`XLEN-1:0]      imm;
        logic [3:0]            op;
        logic [`REG_IDX_W-1:0] rd;
        retire_t               rec;
        bit                    stopped;
        expected.delete();
        pc = `RESET_PC;
        stopped = 1'b0;
        while (!stopped) begin
            inst = image_word(pc);
            op = inst[31:28];
            rd = inst[27:24];
            a = model_regs[inst[23:20]];
            b = model_regs[inst[19:16]];
            imm = {{(`XLEN - 16){inst[15]}}, inst[15:0]};
            next_pc = pc + `PC_STEP;
            rec = '0;
            rec.pc = pc;
            rec.wr_idx = rd;
            rec.wr_en = (op >= op_add && op <= op_addi);
            case (op)
                op_add:  rec.wr_data = a + b;
                op_sub:  rec.wr_data = a - b;
                op_and:  rec.wr_data = a & b;
                op_xor:  rec.wr_data = a ^ b;
                op_addi: rec.wr_data = a + imm;
                op_beq:  next_pc = (a == b) ? pc + imm * `PC_STEP : next_pc;
                op_bne:  next_pc = (a != b) ? pc + imm * `PC_STEP : next_pc;
                op_nop: begin
                end
                op_halt: begin
                    rec.is_halt = 1'b1;
                    exp_status = status_halted;
                    stopped = 1'b1;
                end
                default: begin
                    rec.is_illegal = 1'b1;
                    exp_status = status_illegal;
                    stopped = 1'b1;
                end
            endcase
            // r0 stays zero
            if (rec.wr_en && rd != '0) begin
                model_regs[rd] = rec.wr_data;
            end
            expected.push_back(rec);
            pc = next_pc;
        end
    endtask

    ////////////////////////////////////////
    // checks and test sequencing
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] want);
        if (got !== want) begin
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, want);
            error_count++;
        end
    endtask

    task automatic check_commit();
        retire_t want;
        if (commit.valid) begin
            if (expected.size() == 0) begin
                $display("extra commit from pc 0x%08h after the last expected one", commit.pc);
                error_count++;
            end else begin
                want = expected.pop_front();
                check_value("commit.pc", commit.pc, want.pc);
                check_value("commit.wr_en", commit.wr_en, want.wr_en);
                check_value("commit.is_halt", commit.is_halt, want.is_halt);
                check_value("commit.is_illegal", commit.is_illegal, want.is_illegal);
                // index and data only mean something for writers
                if (want.wr_en) begin
                    check_value("commit.wr_idx", commit.wr_idx, want.wr_idx);
                    check_value("commit.wr_data", commit.wr_data, want.wr_data);
                end
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // reset rises one edge after the request
    task automatic restart_dut();
        @(negedge clock);
        restart <= 1'b1;
        @(negedge clock);
        restart <= 1'b0;
        @(negedge reset);
    endtask

    task automatic run_test(input string name, input int kind);
        int errors_before;
        int cycles;
        errors_before = error_count;
        build_program(kind);
        run_model();
        restart_dut();
        cycles = 0;
        do begin
            @(negedge clock);
            check_commit();
            cycles++;
        end while (status == status_ok && cycles < test_limit);
        if (status == status_ok) begin
            $display("%s never retired a halt or illegal instruction in %0d cycles",
                     name, cycles);
            error_count++;
        end else begin
            // nothing may retire past the stop point
            repeat (tail_cycles) begin
                @(negedge clock);
                check_commit();
            end
        end
        if (expected.size() != 0) begin
            $display("%s is missing %0d commits", name, expected.size());
            error_count++;
        end
        check_value("status", status, exp_status);
        finish_test(name, errors_before);
    endtask

    initial begin
        // outputs settle under the first reset
        @(negedge reset);
        check_value("commit.valid", commit.valid, 1'b0);
        check_value("fetch_addr", fetch_addr, `RESET_PC);
        check_value("status", status, status_ok);
        finish_test("reset_state", 0);
        run_test("independent_alu", kind_indep);
        run_test("dense_deps_a", kind_dense);
        run_test("dense_deps_b", kind_dense);
        run_test("branches_a", kind_branch);
        run_test("branches_b", kind_branch);
        run_test("halt_early", kind_halt);
        run_test("illegal_opcode", kind_illegal);
        $display("tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // hard stop sized from the program lengths
    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tiny_pipe.f
+incdir+include
source/tiny_pipe_pkg.sv
source/pipe_control.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/exec_unit.sv
source/tiny_pipe.sv
test/clock_gen.sv
test/tiny_pipe_tb.sv
